//--- sources.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/pipeIfs.sv
hdl/controlUnit.sv
hdl/hazardUnit.sv
hdl/regFile.sv
hdl/alu.sv
hdl/datapath.sv
hdl/mipsPipe.sv
testbench/tbClockGen.sv
testbench/tbMipsPipe.sv

//--- Bender.yml
package:
  name: mips_pipe

sources:
  - hdl/isaPkg.sv
  - hdl/pipePkg.sv
  - hdl/pipeIfs.sv
  - hdl/controlUnit.sv
  - hdl/hazardUnit.sv
  - hdl/regFile.sv
  - hdl/alu.sv
  - hdl/datapath.sv
  - hdl/mipsPipe.sv
  - target: test
    files:
      - testbench/tbClockGen.sv
      - testbench/tbMipsPipe.sv

//--- testbench/tbMipsPipe.sv
`timescale 1ns/1ns

module tbMipsPipe;

	localparam int memWords     = 256;
	localparam int waitLimit    = 200;
	localparam int settleCycles = 10;

	logic        clk;
	logic        porN;
	logic        testRstN;
	logic        arstN;
	logic [31:0] pc;
	logic [31:0] instr;
	logic        memWrite;
	logic [31:0] dataAddr;
	logic [31:0] writeData;
	logic [31:0] readData;

	// both memories are word indexed
	logic [31:0] imem [0:memWords-1];
	logic [31:0] dmem [0:memWords-1];

	// program under construction with its expected and seen stores
	logic [31:0] prog [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] logAddr [$];
	logic [31:0] logData [$];

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          testsRun;
	int          testsFailed;

	tbClockGen tbClockGen_inst (
		.clk  (clk),
		.porN (porN)
	);

	// power-on reset or a per-test pulse
	assign arstN = porN & testRstN;

	mipsPipe mipsPipe_inst (
		.clk       (clk),
		.arstN     (arstN),
		.pc        (pc),
		.instr     (instr),
		.memWrite  (memWrite),
		.dataAddr  (dataAddr),
		.writeData (writeData),
		.readData  (readData)
	);

	// both reads combinational
	assign instr    = imem[pc[9:2]];
	assign readData = dmem[dataAddr[9:2]];

	// store port writes and logs at the rising edge
	always @(posedge clk) begin
		if (arstN && memWrite) begin
			logAddr.push_back(dataAddr);
			logData.push_back(writeData);
			dmem[dataAddr[9:2]] <= writeData;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[31]};
			lfsr = lfsrNext(lfsr);
		end
		return r;
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// data memory background where every word differs
	function automatic logic [31:0] fillWord(input int idx);
		logic [7:0] i;
		i = idx[7:0];
		return {8'hd4, ~i, i, i ^ 8'h3c};
	endfunction

	// instruction encoders
	function automatic logic [31:0] rtypeWord(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {isaPkg::opRtype, rs, rt, rd, shamt, fn};
	endfunction

	// addi rt, rs, imm and lw/sw rt, imm(rs)
	function automatic logic [31:0] itypeWord(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jumpWord(input logic [31:0] target);
		return {isaPkg::opJ, target[27:2]};
	endfunction

	task automatic clearProgram();
		prog.delete();
		expAddr.delete();
		expData.delete();
	endtask

	task automatic emit(input logic [31:0] w);
		prog.push_back(w);
	endtask

	// jump to itself so the pipeline idles
	task automatic haltHere();
		emit(jumpWord(prog.size() * 4));
	endtask

	task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// program goes in while reset is held for two cycles
	task automatic startProgram();
		@(posedge clk);
		testRstN <= 1'b0;
		@(posedge clk);
		logAddr.delete();
		logData.delete();
		for (int i = 0; i < memWords; i++) begin
			imem[i] <= (i < prog.size()) ? prog[i] : 32'h0;
			dmem[i] <= fillWord(i);
		end
		@(posedge clk);
		testRstN <= 1'b1;
	endtask

	task automatic runAndCheck(input string name);
		int cycles;
		int startErrors;
		startErrors = errors;
		// reset still holds the pipeline in this time step
		checks++;
		assert (pc == 32'h0) else begin
			$display("[FAIL] %s: pc in reset expected %h, actual %h", name, 32'h0, pc);
			errors++;
		end
		checks++;
		assert (memWrite == 1'b0) else begin
			$display("[FAIL] %s: memWrite in reset expected %b, actual %b", name, 1'b0,
				memWrite);
			errors++;
		end
		cycles = 0;
		while (logAddr.size() < expAddr.size() && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (logAddr.size() < expAddr.size()) begin
			$display("%s: timed out after %0d cycles with %0d of %0d stores", name, cycles,
				logAddr.size(), expAddr.size());
			errors++;
		end
		// catch a stray store after the last one
		cycles = 0;
		while (cycles < settleCycles) begin
			@(negedge clk);
			cycles++;
		end
		for (int i = 0; i < expAddr.size(); i++) begin
			checks++;
			assert (i < logAddr.size()) else begin
				$display("%s: store %0d never happened", name, i);
				errors++;
			end
			if (i < logAddr.size()) begin
				assert (logAddr[i] == expAddr[i]) else begin
					$display("[FAIL] %s: store %0d address expected %h, actual %h", name, i,
						expAddr[i], logAddr[i]);
					errors++;
				end
				assert (logData[i] == expData[i]) else begin
					$display("[FAIL] %s: store %0d data expected %h, actual %h", name, i,
						expData[i], logData[i]);
					errors++;
				end
			end
		end
		checks++;
		assert (logAddr.size() <= expAddr.size()) else begin
			$display("%s: %0d stores seen where only %0d belong", name, logAddr.size(),
				expAddr.size());
			errors++;
		end
		testsRun++;
		if (errors == startErrors) begin
			$display("test %s finished, %0d stores correct", name, expAddr.size());
		end else begin
			testsFailed++;
			$display("test %s finished with %0d errors", name, errors - startErrors);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	// each op uses the previous result through memory and writeback forwarding
	task automatic rtypeChain();
		logic [31:0] a, b, c, r4, r5, r6, r7, r8;
		clearProgram();
		a = sext16(randBits(16));
		b = sext16(randBits(16));
		c = sext16(randBits(16));
		emit(itypeWord(isaPkg::opAddi, 5'd1, 5'd0, a[15:0]));
		emit(itypeWord(isaPkg::opAddi, 5'd2, 5'd0, b[15:0]));
		emit(itypeWord(isaPkg::opAddi, 5'd3, 5'd0, c[15:0]));
		emit(rtypeWord(isaPkg::fnAdd, 5'd4, 5'd1, 5'd2, 5'd0));
		emit(rtypeWord(isaPkg::fnSub, 5'd5, 5'd4, 5'd3, 5'd0));
		emit(rtypeWord(isaPkg::fnAnd, 5'd6, 5'd5, 5'd4, 5'd0));
		emit(rtypeWord(isaPkg::fnSlt, 5'd7, 5'd6, 5'd5, 5'd0));
		emit(rtypeWord(isaPkg::fnOr, 5'd8, 5'd7, 5'd6, 5'd0));
		// store data straight from the memory stage
		emit(itypeWord(isaPkg::opSw, 5'd8, 5'd0, 16'h0210));
		emit(itypeWord(isaPkg::opSw, 5'd4, 5'd0, 16'h0200));
		emit(itypeWord(isaPkg::opSw, 5'd5, 5'd0, 16'h0204));
		emit(itypeWord(isaPkg::opSw, 5'd6, 5'd0, 16'h0208));
		emit(itypeWord(isaPkg::opSw, 5'd7, 5'd0, 16'h020c));
		haltHere();
		r4 = a + b;
		r5 = r4 - c;
		r6 = r5 & r4;
		r7 = ($signed(r6) < $signed(r5)) ? 32'd1 : 32'd0;
		r8 = r7 | r6;
		expectStore(32'h210, r8);
		expectStore(32'h200, r4);
		expectStore(32'h204, r5);
		expectStore(32'h208, r6);
		expectStore(32'h20c, r7);
		startProgram();
		runAndCheck("rtypeChain");
	endtask

	// loaded value used by the very next instruction
	task automatic loadUse();
		logic [31:0] v, w, f;
		clearProgram();
		v = sext16(randBits(16));
		w = sext16(randBits(16));
		f = fillWord(32'h180 >> 2);
		emit(itypeWord(isaPkg::opAddi, 5'd1, 5'd0, v[15:0]));
		emit(itypeWord(isaPkg::opAddi, 5'd2, 5'd0, w[15:0]));
		emit(itypeWord(isaPkg::opSw, 5'd1, 5'd0, 16'h0100));
		emit(itypeWord(isaPkg::opLw, 5'd3, 5'd0, 16'h0100));
		emit(rtypeWord(isaPkg::fnAdd, 5'd4, 5'd3, 5'd2, 5'd0));
		emit(itypeWord(isaPkg::opSw, 5'd4, 5'd0, 16'h0104));
		// background word on both operands
		emit(itypeWord(isaPkg::opLw, 5'd5, 5'd0, 16'h0180));
		emit(rtypeWord(isaPkg::fnAdd, 5'd6, 5'd5, 5'd5, 5'd0));
		emit(itypeWord(isaPkg::opSw, 5'd6, 5'd0, 16'h0108));
		// load straight into store data
		emit(itypeWord(isaPkg::opLw, 5'd7, 5'd0, 16'h0100));
		emit(itypeWord(isaPkg::opSw, 5'd7, 5'd0, 16'h010c));
		haltHere();
		expectStore(32'h100, v);
		expectStore(32'h104, v + w);
		expectStore(32'h108, f + f);
		expectStore(32'h10c, v);
		startProgram();
		runAndCheck("loadUse");
	endtask

	// taken and not-taken beq with a marker behind each
	task automatic branchPaths();
		logic [15:0] a16, b16;
		clearProgram();
		a16 = randBits(16);
		b16 = a16 ^ 16'h0001;
		emit(itypeWord(isaPkg::opAddi, 5'd1, 5'd0, a16));
		emit(itypeWord(isaPkg::opAddi, 5'd2, 5'd0, a16));
		emit(itypeWord(isaPkg::opAddi, 5'd3, 5'd0, b16));
		emit(itypeWord(isaPkg::opAddi, 5'd10, 5'd0, 16'h0111));
		emit(itypeWord(isaPkg::opAddi, 5'd11, 5'd0, 16'h0222));
		// word 5 is not taken and would land on 9
		emit(itypeWord(isaPkg::opBeq, 5'd3, 5'd1, 16'd3));
		emit(itypeWord(isaPkg::opSw, 5'd10, 5'd0, 16'h0300));
		// word 7 is taken to 10
		emit(itypeWord(isaPkg::opBeq, 5'd2, 5'd1, 16'd2));
		emit(itypeWord(isaPkg::opSw, 5'd11, 5'd0, 16'h0304));
		emit(itypeWord(isaPkg::opSw, 5'd11, 5'd0, 16'h0308));
		emit(itypeWord(isaPkg::opSw, 5'd1, 5'd0, 16'h030c));
		// word 12 finds its operand still in execute and goes to 15
		emit(itypeWord(isaPkg::opAddi, 5'd12, 5'd1, 16'h0000));
		emit(itypeWord(isaPkg::opBeq, 5'd2, 5'd12, 16'd2));
		emit(itypeWord(isaPkg::opSw, 5'd11, 5'd0, 16'h0310));
		emit(itypeWord(isaPkg::opSw, 5'd11, 5'd0, 16'h0314));
		// word 16 has the same hazard but is not taken
		emit(itypeWord(isaPkg::opAddi, 5'd13, 5'd3, 16'h0000));
		emit(itypeWord(isaPkg::opBeq, 5'd2, 5'd13, 16'd2));
		emit(itypeWord(isaPkg::opSw, 5'd10, 5'd0, 16'h0318));
		emit(itypeWord(isaPkg::opSw, 5'd13, 5'd0, 16'h031c));
		haltHere();
		expectStore(32'h300, 32'h111);
		expectStore(32'h30c, sext16(a16));
		expectStore(32'h318, 32'h111);
		expectStore(32'h31c, sext16(b16));
		startProgram();
		runAndCheck("branchPaths");
	endtask

	// j skips two stores
	task automatic jumpOver();
		logic [15:0] x16, y16;
		clearProgram();
		x16 = randBits(16);
		y16 = randBits(16);
		emit(itypeWord(isaPkg::opAddi, 5'd1, 5'd0, x16));
		emit(itypeWord(isaPkg::opAddi, 5'd2, 5'd0, y16));
		emit(itypeWord(isaPkg::opSw, 5'd1, 5'd0, 16'h03fc));
		// word 3 jumps to word 6
		emit(jumpWord(32'd24));
		emit(itypeWord(isaPkg::opSw, 5'd1, 5'd0, 16'h0400));
		emit(itypeWord(isaPkg::opSw, 5'd1, 5'd0, 16'h0404));
		emit(itypeWord(isaPkg::opSw, 5'd2, 5'd0, 16'h0408));
		haltHere();
		expectStore(32'h3fc, sext16(x16));
		expectStore(32'h408, sext16(y16));
		startProgram();
		runAndCheck("jumpOver");
	endtask

	// sll and a negative immediate plus writes to r0
	task automatic shiftAndImm();
		logic [15:0] v16, neg16;
		logic [31:0] tmp, shifted;
		logic [4:0]  sh;
		clearProgram();
		v16   = randBits(16);
		tmp   = randBits(15);
		neg16 = {1'b1, tmp[14:0]};
		tmp   = randBits(5);
		sh    = tmp[4:0];
		emit(itypeWord(isaPkg::opAddi, 5'd1, 5'd0, v16));
		emit(rtypeWord(isaPkg::fnSll, 5'd2, 5'd0, 5'd1, sh));
		emit(itypeWord(isaPkg::opSw, 5'd2, 5'd0, 16'h0500));
		emit(itypeWord(isaPkg::opAddi, 5'd3, 5'd1, neg16));
		emit(itypeWord(isaPkg::opSw, 5'd3, 5'd0, 16'h0504));
		// r0 must stay zero through both paths
		emit(itypeWord(isaPkg::opAddi, 5'd0, 5'd0, 16'h1234));
		emit(itypeWord(isaPkg::opSw, 5'd0, 5'd0, 16'h0508));
		emit(rtypeWord(isaPkg::fnAdd, 5'd0, 5'd1, 5'd1, 5'd0));
		emit(rtypeWord(isaPkg::fnAdd, 5'd4, 5'd0, 5'd2, 5'd0));
		emit(itypeWord(isaPkg::opSw, 5'd4, 5'd0, 16'h050c));
		haltHere();
		shifted = sext16(v16) << sh;
		expectStore(32'h500, shifted);
		expectStore(32'h504, sext16(v16) + sext16(neg16));
		expectStore(32'h508, 32'h0);
		expectStore(32'h50c, shifted);
		startProgram();
		runAndCheck("shiftAndImm");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		lfsr        = 32'h2bcd;
		errors      = 0;
		checks      = 0;
		testsRun    = 0;
		testsFailed = 0;
		testRstN <= 1'b1;
		for (int i = 0; i < memWords; i++) begin
			imem[i] <= 32'h0;
			dmem[i] <= fillWord(i);
		end
		cycles = 0;
		while (porN !== 1'b1 && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (porN !== 1'b1) begin
			$display("power-on reset was never released");
			errors++;
		end
		rtypeChain();
		loadUse();
		branchPaths();
		jumpOver();
		shiftAndImm();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
			checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- testbench/tbClockGen.sv
`timescale 1ns/1ns

module tbClockGen (
	output logic clk,
	output logic porN
);

	// 4 ns period
	localparam int halfPeriod  = 2;
	localparam int resetCycles = 2;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// power-on reset, released on a rising edge
	initial begin
		porN <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		porN <= 1'b1;
	end

endmodule

//--- hdl/mipsPipe.sv
`timescale 1ns/1ns

module mipsPipe (
	input  logic                     clk,
	input  logic                     arstN,
	// instruction memory
	output logic [isaPkg::wordW-1:0] pc,
	input  logic [isaPkg::wordW-1:0] instr,
	// data memory
	output logic                     memWrite,
	output logic [isaPkg::wordW-1:0] dataAddr,
	output logic [isaPkg::wordW-1:0] writeData,
	input  logic [isaPkg::wordW-1:0] readData
);

	ctrlIf   ctrlBus ();
	hazardIf hazBus ();

	controlUnit controlUnit_inst (
		.clk   (clk),
		.arstN (arstN),
		.ctrl  (ctrlBus.ctrl),
		.haz   (hazBus.ctrl)
	);

	hazardUnit hazardUnit_inst (
		.haz  (hazBus.hazard),
		.ctrl (ctrlBus.hazard)
	);

	datapath datapath_inst (
		.clk       (clk),
		.arstN     (arstN),
		.pc        (pc),
		.instr     (instr),
		.memWrite  (memWrite),
		.dataAddr  (dataAddr),
		.writeData (writeData),
		.readData  (readData),
		.ctrl      (ctrlBus.dp),
		.haz       (hazBus.dp)
	);

endmodule

//--- hdl/datapath.sv
`timescale 1ns/1ns

module datapath (
	input  logic                     clk,
	input  logic                     arstN,
	output logic [isaPkg::wordW-1:0] pc,
	input  logic [isaPkg::wordW-1:0] instr,
	output logic                     memWrite,
	output logic [isaPkg::wordW-1:0] dataAddr,
	output logic [isaPkg::wordW-1:0] writeData,
	input  logic [isaPkg::wordW-1:0] readData,
	ctrlIf.dp                        ctrl,
	hazardIf.dp                      haz
);

	// fetch to decode
	typedef struct packed {
		logic [isaPkg::wordW-1:0] instr;
		logic [isaPkg::wordW-1:0] pcPlus4;
	} fdT;

	// decode to execute
	typedef struct packed {
		logic [isaPkg::wordW-1:0]    srcA;
		logic [isaPkg::wordW-1:0]    srcB;
		logic [isaPkg::wordW-1:0]    signImm;
		logic [isaPkg::regAddrW-1:0] rs;
		logic [isaPkg::regAddrW-1:0] rt;
		logic [isaPkg::regAddrW-1:0] rd;
		logic [isaPkg::shamtW-1:0]   shamt;
	} deT;

	// execute to memory
	typedef struct packed {
		logic [isaPkg::wordW-1:0]    aluOut;
		logic [isaPkg::wordW-1:0]    writeData;
		logic [isaPkg::regAddrW-1:0] writeReg;
	} emT;

	// memory to writeback
	typedef struct packed {
		logic [isaPkg::wordW-1:0]    aluOut;
		logic [isaPkg::wordW-1:0]    readData;
		logic [isaPkg::regAddrW-1:0] writeReg;
	} mwT;

	fdT fd;
	deT de;
	emT em;
	mwT mw;

	logic [isaPkg::wordW-1:0]    pcPlus4F, pcNext, branchTarget, jumpTarget;
	logic [isaPkg::wordW-1:0]    instrD, signImmD, rd1D, rd2D, srcAD, srcBD;
	logic [isaPkg::wordW-1:0]    srcAE, srcBE, aluBE, aluOutE, resultW;
	logic [isaPkg::regAddrW-1:0] writeRegE;

	////////////////////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////////////////////

	assign pcPlus4F = pc + 32'd4;

	// jump over branch over sequential
	assign pcNext = ctrl.jumpD ? jumpTarget : (ctrl.pcSrcD ? branchTarget : pcPlus4F);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= '0;
		else if (!haz.stallF)
			pc <= pcNext;
	end

	// fetched word dropped on redirect
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			fd <= '0;
		else if (haz.flushD)
			fd <= '0;
		else if (!haz.stallD)
			fd <= '{instr: instr, pcPlus4: pcPlus4F};
	end

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	assign instrD = fd.instr;
	assign ctrl.opD   = instrD[isaPkg::opLsb +: isaPkg::opW];
	assign ctrl.functD = instrD[0 +: isaPkg::opW];
	assign haz.rsD    = instrD[isaPkg::rsLsb +: isaPkg::regAddrW];
	assign haz.rtD    = instrD[isaPkg::rtLsb +: isaPkg::regAddrW];

	// sign extend
	assign signImmD = {{(isaPkg::wordW - isaPkg::immW){instrD[isaPkg::immW-1]}},
		instrD[0 +: isaPkg::immW]};
	assign branchTarget = fd.pcPlus4 + (signImmD << 2);
	// upper nibble of pc+4, word target
	assign jumpTarget = {fd.pcPlus4[isaPkg::wordW-1 -: 4], instrD[0 +: isaPkg::targetW], 2'b00};

	regFile regFile_inst (
		.clk   (clk),
		.arstN (arstN),
		.we    (ctrl.regWriteW),
		.ra1   (haz.rsD),
		.ra2   (haz.rtD),
		.wa    (mw.writeReg),
		.wd    (resultW),
		.rd1   (rd1D),
		.rd2   (rd2D)
	);

	// branch compare sees the memory-stage alu result
	assign srcAD = haz.fwdAD ? em.aluOut : rd1D;
	assign srcBD = haz.fwdBD ? em.aluOut : rd2D;
	assign ctrl.equalD = (srcAD == srcBD);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			de <= '0;
		else if (haz.flushE)
			de <= '0;
		else
			de <= '{srcA: rd1D, srcB: rd2D, signImm: signImmD, rs: haz.rsD, rt: haz.rtD,
				rd: instrD[isaPkg::rdLsb +: isaPkg::regAddrW],
				shamt: instrD[isaPkg::shamtLsb +: isaPkg::shamtW]};
	end

	////////////////////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////////////////////

	// operand forwarding
	always_comb begin
		case (haz.fwdAE)
			pipePkg::fwdMem: srcAE = em.aluOut;
			pipePkg::fwdWb:  srcAE = resultW;
			default:         srcAE = de.srcA;
		endcase
		case (haz.fwdBE)
			pipePkg::fwdMem: srcBE = em.aluOut;
			pipePkg::fwdWb:  srcBE = resultW;
			default:         srcBE = de.srcB;
		endcase
	end

	assign aluBE     = ctrl.aluSrcE ? de.signImm : srcBE;
	assign writeRegE = ctrl.regDstE ? de.rd : de.rt;
	assign haz.rsE   = de.rs;
	assign haz.rtE   = de.rt;
	assign haz.writeRegE = writeRegE;

	alu alu_inst (
		.a     (srcAE),
		.b     (aluBE),
		.shamt (de.shamt),
		.op    (ctrl.aluOpE),
		.y     (aluOutE)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			em <= '0;
		else
			em <= '{aluOut: aluOutE, writeData: srcBE, writeReg: writeRegE};
	end

	////////////////////////////////////////////////////////////////////////////
	// memory and writeback
	////////////////////////////////////////////////////////////////////////////

	assign memWrite      = ctrl.memWriteM;
	assign dataAddr      = em.aluOut;
	assign writeData     = em.writeData;
	assign haz.writeRegM = em.writeReg;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			mw <= '0;
		else
			mw <= '{aluOut: em.aluOut, readData: readData, writeReg: em.writeReg};
	end

	assign resultW       = ctrl.memToRegW ? mw.readData : mw.aluOut;
	assign haz.writeRegW = mw.writeReg;

	// only word fetches
	assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00);

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu (
	input  logic [isaPkg::wordW-1:0]  a,
	input  logic [isaPkg::wordW-1:0]  b,
	input  logic [isaPkg::shamtW-1:0] shamt,
	input  isaPkg::aluOpT             op,
	output logic [isaPkg::wordW-1:0]  y
);

	always_comb begin
		case (op)
			isaPkg::aluAdd: y = a + b;
			isaPkg::aluSub: y = a - b;
			isaPkg::aluAnd: y = a & b;
			isaPkg::aluOr:  y = a | b;
			// signed compare
			isaPkg::aluSlt: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			// shift the rt operand, rs unused
			isaPkg::aluSll: y = b << shamt;
			default:        y = '0;
		endcase
	end

	// op comes from the execute-stage control word, never X
	always_comb begin
		assert final (!$isunknown(op));
	end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ns

module regFile (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        we,
	input  logic [isaPkg::regAddrW-1:0] ra1,
	input  logic [isaPkg::regAddrW-1:0] ra2,
	input  logic [isaPkg::regAddrW-1:0] wa,
	input  logic [isaPkg::wordW-1:0]    wd,
	output logic [isaPkg::wordW-1:0]    rd1,
	output logic [isaPkg::wordW-1:0]    rd2
);

	// r0 has no storage
	logic [isaPkg::wordW-1:0] regs [1:31];

	// falling edge, decode reads the new value in the same cycle
	always_ff @(negedge clk) begin
		if (we && wa != '0)
			regs[wa] <= wd;
	end

	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

	// write address must be known when enabled
	assert property (@(negedge clk) disable iff (!arstN) we |-> !$isunknown(wa));

endmodule

//--- hdl/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
	hazardIf.hazard haz,
	ctrlIf.hazard   ctrl
);

	logic lwStall;
	logic branchStall;

	// memory stage wins over writeback and register 0 never forwards
	function automatic pipePkg::fwdSelT fwdSel(input logic [isaPkg::regAddrW-1:0] src,
			input logic regWriteM, input logic [isaPkg::regAddrW-1:0] writeRegM,
			input logic regWriteW, input logic [isaPkg::regAddrW-1:0] writeRegW);
		if (src == '0)
			return pipePkg::fwdNone;
		if (regWriteM && src == writeRegM)
			return pipePkg::fwdMem;
		if (regWriteW && src == writeRegW)
			return pipePkg::fwdWb;
		return pipePkg::fwdNone;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// forwarding
	////////////////////////////////////////////////////////////////////////////

	assign haz.fwdAE = fwdSel(haz.rsE, ctrl.regWriteM, haz.writeRegM,
		ctrl.regWriteW, haz.writeRegW);
	assign haz.fwdBE = fwdSel(haz.rtE, ctrl.regWriteM, haz.writeRegM,
		ctrl.regWriteW, haz.writeRegW);

	// branch compare in decode takes the memory-stage alu result
	assign haz.fwdAD = (haz.rsD != '0) && ctrl.regWriteM && (haz.rsD == haz.writeRegM);
	assign haz.fwdBD = (haz.rtD != '0) && ctrl.regWriteM && (haz.rtD == haz.writeRegM);

	////////////////////////////////////////////////////////////////////////////
	// stalls and flushes
	////////////////////////////////////////////////////////////////////////////

	// load in execute feeding decode
	assign lwStall = ctrl.memToRegE
		&& ((haz.writeRegE == haz.rsD) || (haz.writeRegE == haz.rtD));

	// branch operand still in execute or still loading in memory
	assign branchStall = ctrl.branchD && (
		(ctrl.regWriteE && ((haz.writeRegE == haz.rsD) || (haz.writeRegE == haz.rtD)))
		|| (ctrl.memToRegM && ((haz.writeRegM == haz.rsD) || (haz.writeRegM == haz.rtD))));

	assign haz.stallF = lwStall | branchStall;
	assign haz.stallD = lwStall | branchStall;
	assign haz.flushE = lwStall | branchStall;
	// squash the fetched instr unless decode holds
	assign haz.flushD = (ctrl.pcSrcD | ctrl.jumpD) & ~haz.stallD;

endmodule

//--- hdl/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
	input logic   clk,
	input logic   arstN,
	ctrlIf.ctrl   ctrl,
	hazardIf.ctrl haz
);

	pipePkg::ctrlET ctrlD;
	pipePkg::ctrlET ctrlE;
	pipePkg::ctrlMT ctrlM;
	logic           branch;
	logic           jump;
	logic           regWriteW;
	logic           memToRegW;

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrlD  = pipePkg::ctrlBubble;
		branch = 1'b0;
		jump   = 1'b0;
		case (ctrl.opD)
			isaPkg::opRtype: begin
				ctrlD.m.regWrite = 1'b1;
				ctrlD.regDst     = 1'b1;
				case (ctrl.functD)
					isaPkg::fnAdd: ctrlD.aluOp = isaPkg::aluAdd;
					isaPkg::fnSub: ctrlD.aluOp = isaPkg::aluSub;
					isaPkg::fnAnd: ctrlD.aluOp = isaPkg::aluAnd;
					isaPkg::fnOr:  ctrlD.aluOp = isaPkg::aluOr;
					isaPkg::fnSlt: ctrlD.aluOp = isaPkg::aluSlt;
					isaPkg::fnSll: ctrlD.aluOp = isaPkg::aluSll;
					// unknown funct, no write
					default:       ctrlD.m.regWrite = 1'b0;
				endcase
			end
			isaPkg::opLw: begin
				ctrlD.m.regWrite = 1'b1;
				ctrlD.m.memToReg = 1'b1;
				ctrlD.aluSrc     = 1'b1;
			end
			isaPkg::opSw: begin
				ctrlD.m.memWrite = 1'b1;
				ctrlD.aluSrc     = 1'b1;
			end
			isaPkg::opAddi: begin
				ctrlD.m.regWrite = 1'b1;
				ctrlD.aluSrc     = 1'b1;
			end
			// resolved in decode, rest of the word stays a bubble
			isaPkg::opBeq: branch = 1'b1;
			isaPkg::opJ:   jump   = 1'b1;
			default: ;
		endcase
	end

	// redirect right out of decode
	assign ctrl.branchD = branch;
	assign ctrl.jumpD   = jump;
	assign ctrl.pcSrcD  = branch & ctrl.equalD;

	////////////////////////////////////////////////////////////////////////////
	// stage registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrlE     <= pipePkg::ctrlBubble;
			ctrlM     <= pipePkg::ctrlBubble.m;
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			// bubble into execute on a stall
			ctrlE     <= haz.flushE ? pipePkg::ctrlBubble : ctrlD;
			ctrlM     <= ctrlE.m;
			regWriteW <= ctrlM.regWrite;
			memToRegW <= ctrlM.memToReg;
		end
	end

	assign ctrl.aluOpE    = ctrlE.aluOp;
	assign ctrl.aluSrcE   = ctrlE.aluSrc;
	assign ctrl.regDstE   = ctrlE.regDst;
	assign ctrl.memToRegE = ctrlE.m.memToReg;
	assign ctrl.regWriteE = ctrlE.m.regWrite;
	assign ctrl.memToRegM = ctrlM.memToReg;
	assign ctrl.regWriteM = ctrlM.regWrite;
	assign ctrl.memWriteM = ctrlM.memWrite;
	assign ctrl.memToRegW = memToRegW;
	assign ctrl.regWriteW = regWriteW;

	// a store never writes back
	assert property (@(posedge clk) disable iff (!arstN) !(ctrlM.memWrite && ctrlM.regWrite));

endmodule

//--- hdl/pipeIfs.sv
`timescale 1ns/1ns

// control signals between the controller and the datapath
interface ctrlIf;
	// decode stage
	logic [isaPkg::opW-1:0] opD;
	logic [isaPkg::opW-1:0] functD;
	logic                   equalD;
	logic                   pcSrcD;
	logic                   jumpD;
	logic                   branchD;
	// execute stage
	isaPkg::aluOpT aluOpE;
	logic          aluSrcE;
	logic          regDstE;
	logic          memToRegE;
	logic          regWriteE;
	// memory stage
	logic memToRegM;
	logic regWriteM;
	logic memWriteM;
	// writeback stage
	logic memToRegW;
	logic regWriteW;

	modport ctrl (
		input  opD, functD, equalD,
		output pcSrcD, jumpD, branchD,
		output aluOpE, aluSrcE, regDstE, memToRegE, regWriteE,
		output memToRegM, regWriteM, memWriteM,
		output memToRegW, regWriteW
	);

	modport dp (
		output opD, functD, equalD,
		input  pcSrcD, jumpD,
		input  aluOpE, aluSrcE, regDstE,
		input  memWriteM, memToRegW, regWriteW
	);

	// hazard unit only looks
	modport hazard (
		input branchD, pcSrcD, jumpD,
		input memToRegE, regWriteE, memToRegM, regWriteM, regWriteW
	);
endinterface

// register numbers in flight and the stall, flush and forward controls
interface hazardIf;
	logic [isaPkg::regAddrW-1:0] rsD, rtD, rsE, rtE;
	logic [isaPkg::regAddrW-1:0] writeRegE, writeRegM, writeRegW;
	logic                        stallF, stallD, flushD, flushE;
	// decode compare forwards from memory only
	logic                        fwdAD, fwdBD;
	pipePkg::fwdSelT             fwdAE, fwdBE;

	modport dp (
		output rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
		input  stallF, stallD, flushD, flushE, fwdAD, fwdBD, fwdAE, fwdBE
	);

	modport hazard (
		input  rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
		output stallF, stallD, flushD, flushE, fwdAD, fwdBD, fwdAE, fwdBE
	);

	modport ctrl (
		input flushE
	);
endinterface

//--- hdl/pipePkg.sv
package pipePkg;

	// execute-stage operand source
	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdWb   = 2'b01,
		fwdMem  = 2'b10
	} fwdSelT;

	////////////////////////////////////////////////////////////////////////////
	// control words, one per stage group
	////////////////////////////////////////////////////////////////////////////

	// memory and writeback part
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
	} ctrlMT;

	// execute part wraps the later stages
	typedef struct packed {
		ctrlMT         m;
		isaPkg::aluOpT aluOp;
		logic          aluSrc;
		logic          regDst;
	} ctrlET;

	// bubble, nothing written anywhere
	localparam ctrlET ctrlBubble = '{
		m:      '{regWrite: 1'b0, memToReg: 1'b0, memWrite: 1'b0},
		aluOp:  isaPkg::aluAdd,
		aluSrc: 1'b0,
		regDst: 1'b0
	};

endpackage

//--- hdl/isaPkg.sv
package isaPkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int wordW    = 32;
	localparam int regAddrW = 5;
	// opcode and funct fields share one width
	localparam int opW      = 6;
	localparam int shamtW   = 5;
	localparam int immW     = 16;
	// j-type target field
	localparam int targetW  = 26;

	// lsb position of each instruction field
	localparam int opLsb    = 26;
	localparam int rsLsb    = 21;
	localparam int rtLsb    = 16;
	localparam int rdLsb    = 11;
	localparam int shamtLsb = 6;

	////////////////////////////////////////////////////////////////////////////
	// opcodes and function codes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [opW-1:0] opRtype = 6'b000000;
	localparam logic [opW-1:0] opJ     = 6'b000010;
	localparam logic [opW-1:0] opBeq   = 6'b000100;
	localparam logic [opW-1:0] opAddi  = 6'b001000;
	localparam logic [opW-1:0] opLw    = 6'b100011;
	localparam logic [opW-1:0] opSw    = 6'b101011;

	// sll is all zero, so an all-zero word is a nop
	localparam logic [opW-1:0] fnSll = 6'b000000;
	localparam logic [opW-1:0] fnAdd = 6'b100000;
	localparam logic [opW-1:0] fnSub = 6'b100010;
	localparam logic [opW-1:0] fnAnd = 6'b100100;
	localparam logic [opW-1:0] fnOr  = 6'b100101;
	localparam logic [opW-1:0] fnSlt = 6'b101010;

	// alu operation select
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSll
	} aluOpT;

endpackage
